// File: lcdBoardOverlay.f
logic/boardPkg.sv
logic/rasterTiming.sv
logic/boardStore.sv
logic/pixelRender.sv
logic/lcdBoardOverlay.sv
verif/pixelChecker.sv
verif/tbTop.sv

// File: logic/boardPkg.sv
package boardPkg;

	// ==================================================
	// Board dimensions
	// ==================================================
	localparam int COLOUR_W   = 3;
	localparam int NUM_ROWS   = 8;
	localparam int GUESS_COLS = 4;
	localparam int ROW_W      = 3;

	// ==================================================
	// Colour and key-peg codes
	// ==================================================
	typedef enum logic [COLOUR_W-1:0] {
		pegEmpty  = 3'd0,
		pegRed    = 3'd1,
		pegGreen  = 3'd2,
		pegBlue   = 3'd3,
		pegOrange = 3'd4,
		pegPurple = 3'd5,
		pegYellow = 3'd6
	} pegColour_e;

	typedef enum logic [1:0] {
		keyNone  = 2'd0,
		keyBlack = 2'd1, // Right colour, right place
		keyWhite = 2'd2  // Right colour, wrong place
	} keyPeg_e;

	// ==================================================
	// Structs
	// ==================================================
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// One raster position with its sync flags
	typedef struct packed {
		logic [10:0] x;
		logic [9:0]  y;
		logic        hd;  // Low at x 0
		logic        vd;  // Low on line 0
		logic        den;
	} raster_t;

	typedef pegColour_e [GUESS_COLS-1:0] guess_t; // Index 0 is the top cell
	typedef keyPeg_e [3:0] keys_t;

	// Empty maps to black but is never drawn
	function automatic rgb_t paletteRgb(pegColour_e colour);
		case (colour)
			pegRed:    return '{red: 8'hff, green: 8'h00, blue: 8'h00};
			pegGreen:  return '{red: 8'h00, green: 8'hff, blue: 8'h00};
			pegBlue:   return '{red: 8'h00, green: 8'h00, blue: 8'hff};
			pegOrange: return '{red: 8'hff, green: 8'ha5, blue: 8'h00};
			pegPurple: return '{red: 8'h80, green: 8'h00, blue: 8'h80};
			pegYellow: return '{red: 8'hff, green: 8'hff, blue: 8'h00};
			default:   return '{red: 8'h00, green: 8'h00, blue: 8'h00};
		endcase
	endfunction

endpackage

// File: logic/boardStore.sv
`timescale 1ns/1ps

module boardStore import boardPkg::*; (
	input  logic             iCLK,
	input  logic             iRST_n,
	// Commit side
	input  logic             nextRound,
	input  logic [ROW_W-1:0] currentRow,
	input  guess_t           liveGuess,
	input  logic [2:0]       blackPegs,
	input  logic [2:0]       whitePegs,
	// Lookup side
	input  logic [ROW_W-1:0] cellRow,
	output guess_t           storedGuess,
	output keys_t            storedKeys
);

	guess_t     guessMem [NUM_ROWS];
	keys_t      keyMem [NUM_ROWS];
	keys_t      commitKeys;
	logic [3:0] pegTotal;

	// ==================================================
	// Key-peg expansion
	// ==================================================
	// Black slots first, then white, rest stay empty
	always_comb
	begin
		pegTotal = {1'b0, blackPegs} + {1'b0, whitePegs};
		for (int slot = 0; slot < 4; slot++)
		begin
			if (slot < blackPegs)
				commitKeys[slot] = keyBlack;
			else if (slot < pegTotal)
				commitKeys[slot] = keyWhite;
			else
				commitKeys[slot] = keyNone;
		end
	end

	// ==================================================
	// Row storage
	// ==================================================
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			for (int r = 0; r < NUM_ROWS; r++)
			begin
				guessMem[r] <= {GUESS_COLS{pegEmpty}};
				keyMem[r]   <= {4{keyNone}};
			end
		end
		else if (nextRound)
		begin
			guessMem[currentRow] <= liveGuess;
			keyMem[currentRow]   <= commitKeys; // All four slots in one cycle
		end
	end

	// Combinational read so the renderer sees a commit one cycle later
	assign storedGuess = guessMem[cellRow];
	assign storedKeys  = keyMem[cellRow];

	// Score can never hold more pegs than there are slots
	pegCountLegal: assert property (@(posedge iCLK) disable iff (!iRST_n)
		nextRound |-> (pegTotal <= 4'd4))
		else $error("Key-peg count too large: black %0d white %0d",
			blackPegs, whitePegs);

endmodule

// File: logic/lcdBoardOverlay.sv
`timescale 1ns/1ps

module lcdBoardOverlay import boardPkg::*; #(
	// Panel timing
	parameter int H_LINE    = 1056,
	parameter int H_BLANK   = 216,
	parameter int H_FRONT   = 40,
	parameter int V_LINE    = 525,
	parameter int V_BACK    = 35,
	parameter int V_FRONT   = 10,
	// Board geometry
	parameter int X_BASE    = 215,
	parameter int Y_BASE    = 34,
	parameter int X_PITCH   = 100,
	parameter int Y_PITCH   = 96,
	parameter int RADIUS_SQ = 1681 // 41 squared
) (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  rgb_t             bgPixel,
	input  logic [ROW_W-1:0] currentRow,
	input  guess_t           liveGuess,
	input  logic [2:0]       blackPegs,
	input  logic [2:0]       whitePegs,
	input  logic             nextRound,
	output logic             lcdHd,
	output logic             lcdVd,
	output logic             lcdDen,
	output rgb_t             lcdPixel
);

	raster_t          rasterPos;
	logic [ROW_W-1:0] cellRow;
	guess_t           storedGuess;
	keys_t            storedKeys;

	// ==================================================
	// Timing, store, renderer
	// ==================================================
	rasterTiming #(
		.H_LINE (H_LINE),
		.H_BLANK(H_BLANK),
		.H_FRONT(H_FRONT),
		.V_LINE (V_LINE),
		.V_BACK (V_BACK),
		.V_FRONT(V_FRONT)
	) timingGen (
		.iCLK     (iCLK),
		.iRST_n   (iRST_n),
		.rasterPos(rasterPos)
	);

	boardStore store (
		.iCLK       (iCLK),
		.iRST_n     (iRST_n),
		.nextRound  (nextRound),
		.currentRow (currentRow),
		.liveGuess  (liveGuess),
		.blackPegs  (blackPegs),
		.whitePegs  (whitePegs),
		.cellRow    (cellRow),
		.storedGuess(storedGuess),
		.storedKeys (storedKeys)
	);

	pixelRender #(
		.X_BASE   (X_BASE),
		.Y_BASE   (Y_BASE),
		.X_PITCH  (X_PITCH),
		.Y_PITCH  (Y_PITCH),
		.RADIUS_SQ(RADIUS_SQ)
	) render (
		.iCLK       (iCLK),
		.iRST_n     (iRST_n),
		.rasterPos  (rasterPos),
		.bgPixel    (bgPixel),
		.currentRow (currentRow),
		.liveGuess  (liveGuess),
		.storedGuess(storedGuess),
		.storedKeys (storedKeys),
		.cellRow    (cellRow),
		.lcdHd      (lcdHd),
		.lcdVd      (lcdVd),
		.lcdDen     (lcdDen),
		.lcdPixel   (lcdPixel)
	);

endmodule

// File: logic/pixelRender.sv
`timescale 1ns/1ps

module pixelRender import boardPkg::*; #(
	parameter int X_BASE    = 215,
	parameter int Y_BASE    = 34,
	parameter int X_PITCH   = 100,
	parameter int Y_PITCH   = 96,
	parameter int RADIUS_SQ = 1681
) (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  raster_t          rasterPos,
	input  rgb_t             bgPixel,
	input  logic [ROW_W-1:0] currentRow,
	input  guess_t           liveGuess,
	input  guess_t           storedGuess,
	input  keys_t            storedKeys,
	output logic [ROW_W-1:0] cellRow,
	output logic             lcdHd,
	output logic             lcdVd,
	output logic             lcdDen,
	output rgb_t             lcdPixel
);

	logic [3:0]  boardRow;  // 0..8 inside den
	logic [2:0]  cellCol;   // 0..5 inside den
	logic [10:0] xCentre;
	logic [9:0]  yCentre;
	logic        xPast;
	logic        yPast;
	logic [10:0] xDist;
	logic [9:0]  yDist;
	logic [22:0] distSq;
	logic        inCircle;
	guess_t      rowGuess;
	pegColour_e  cellCode;
	keyPeg_e     keyCode;
	rgb_t        pixNext;

	// ==================================================
	// Cell geometry
	// ==================================================
	always_comb
	begin
		boardRow = 4'((rasterPos.x - 11'(X_BASE)) / X_PITCH); // Rows run left to right
		cellCol  = 3'((rasterPos.y - 10'(Y_BASE)) / Y_PITCH);
		xCentre  = 11'(X_BASE + X_PITCH * boardRow + X_PITCH / 2);
		yCentre  = 10'(Y_BASE + Y_PITCH * cellCol + Y_PITCH / 2);
		xPast    = (rasterPos.x >= xCentre);
		yPast    = (rasterPos.y >= yCentre);
		xDist    = xPast ? rasterPos.x - xCentre : xCentre - rasterPos.x;
		yDist    = yPast ? rasterPos.y - yCentre : yCentre - rasterPos.y;
		distSq   = xDist * xDist + yDist * yDist;
		inCircle = (distSq < 23'(RADIUS_SQ));
	end

	assign cellRow = boardRow[ROW_W-1:0];

	// ==================================================
	// Pixel selection
	// ==================================================
	always_comb
	begin
		rowGuess = (cellRow == currentRow) ? liveGuess : storedGuess; // Live row
		cellCode = rowGuess[cellCol[1:0]];
		keyCode  = storedKeys[{xPast, yPast}];
		if (!rasterPos.den)
			pixNext = '0;
		else if (boardRow >= 4'(NUM_ROWS))
			pixNext = bgPixel;
		else if (cellCol < 3'(GUESS_COLS))
		begin
			if (inCircle && cellCode != pegEmpty)
				pixNext = paletteRgb(cellCode);
			else
				pixNext = bgPixel;
		end
		else if (cellCol == 3'(GUESS_COLS))
		begin
			case (keyCode) // One quadrant per slot
				keyBlack: pixNext = '{red: 8'h00, green: 8'h00, blue: 8'h00};
				keyWhite: pixNext = '{red: 8'hff, green: 8'hff, blue: 8'hff};
				default:  pixNext = bgPixel;
			endcase
		end
		else
			pixNext = bgPixel;
	end

	// Output stage one cycle behind rasterPos
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			lcdHd    <= 1'b0;
			lcdVd    <= 1'b0;
			lcdDen   <= 1'b0;
			lcdPixel <= '0;
		end
		else
		begin
			lcdHd    <= rasterPos.hd;
			lcdVd    <= rasterPos.vd;
			lcdDen   <= rasterPos.den;
			lcdPixel <= pixNext;
		end
	end

endmodule

// File: logic/rasterTiming.sv
`timescale 1ns/1ps

module rasterTiming import boardPkg::*; #(
	parameter int H_LINE  = 1056,
	parameter int H_BLANK = 216,
	parameter int H_FRONT = 40,
	parameter int V_LINE  = 525,
	parameter int V_BACK  = 35,
	parameter int V_FRONT = 10
) (
	input  logic    iCLK,
	input  logic    iRST_n,
	output raster_t rasterPos
);

	logic        lineEnd;
	logic [10:0] xNext;
	logic [9:0]  yNext;
	logic        denNext;

	// Flags derive from the next position so they line up with x and y
	always_comb
	begin
		lineEnd = (rasterPos.x == 11'(H_LINE - 1));
		xNext   = lineEnd ? 11'd0 : rasterPos.x + 11'd1;
		if (!lineEnd)
			yNext = rasterPos.y;
		else if (rasterPos.y == 10'(V_LINE - 1))
			yNext = 10'd0; // Frame wrap
		else
			yNext = rasterPos.y + 10'd1;
		denNext = (xNext >= 11'(H_BLANK)) && (xNext < 11'(H_LINE - H_FRONT)) &&
			(yNext >= 10'(V_BACK)) && (yNext < 10'(V_LINE - V_FRONT));
	end

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			rasterPos <= '0;
		else
		begin
			rasterPos.x   <= xNext;
			rasterPos.y   <= yNext;
			rasterPos.hd  <= (xNext != 11'd0);
			rasterPos.vd  <= (yNext != 10'd0);
			rasterPos.den <= denNext;
		end
	end

	// Counters never run past the line or frame length
	xInRange: assert property (@(posedge iCLK) disable iff (!iRST_n)
		rasterPos.x < 11'(H_LINE))
		else $error("x counter out of range: %0d", rasterPos.x);
	yInRange: assert property (@(posedge iCLK) disable iff (!iRST_n)
		rasterPos.y < 10'(V_LINE))
		else $error("y counter out of range: %0d", rasterPos.y);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the LCD board overlay testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbTop \
	-f lcdBoardOverlay.f -o simTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simTb > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation returned an error status"
	exit 1
fi
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	exit 0
fi
exit 1

// File: verif/board_golden.txt
# B background rgb | C row c0 c1 c2 c3 black white | L live row c0 c1 c2 c3
# P x y expected rgb
B 3c5a78
C 0 1 2 3 4 1 2
C 1 5 6 0 1 4 0
C 2 2 2 6 5 0 3
C 3 3 0 0 4 2 1
L 3 6 1 2 0
P 265 82 ff0000
P 265 370 ffa500
P 305 82 ff0000
P 306 82 3c5a78
P 240 440 000000
P 240 490 ffffff
P 290 440 ffffff
P 290 490 3c5a78
P 365 82 800080
P 365 274 3c5a78
P 390 490 000000
P 490 440 ffffff
P 490 490 3c5a78
P 565 82 ffff00
P 565 370 3c5a78
P 590 440 ffffff
P 765 82 3c5a78
P 1015 100 3c5a78
P 265 514 3c5a78
P 100 100 000000

// File: verif/pixelChecker.sv
`timescale 1ns/1ps

module pixelChecker import boardPkg::*; #(
	parameter int H_LINE  = 1056,
	parameter int H_BLANK = 216,
	parameter int H_FRONT = 40,
	parameter int V_LINE  = 525,
	parameter int V_BACK  = 35,
	parameter int V_FRONT = 10
) (
	input  logic iCLK,
	input  logic iRST_n,
	input  logic lcdHd,
	input  logic lcdVd,
	input  logic lcdDen,
	input  rgb_t lcdPixel,
	input  logic startCheck,
	output logic checkDone,
	output int   errorCount,
	output int   probesSeen
);

	logic [23:0] probeRgb [int]; // Keyed by y*H_LINE+x
	int          probeNum [int];
	int          probeCount = 0;
	logic        armed = 1'b0;
	logic        startSeen = 1'b0;
	int          x = 0;
	int          y = 0;
	bit          first = 1'b1;
	bit          checking = 1'b0;

	initial
	begin
		checkDone  = 1'b0;
		errorCount = 0;
		probesSeen = 0;
	end

	task addProbe(input int px, input int py, input logic [23:0] rgb);
		probeRgb[py * H_LINE + px] = rgb;
		probeNum[py * H_LINE + px] = probeCount;
		probeCount++;
	endtask

	task reportMismatch(input string name, input logic [23:0] expVal, input logic [23:0] actVal);
		errorCount++;
		$display("CHECK FAILED %s expected %06h actual %06h", name, expVal, actVal);
	endtask

	// First posedge out of reset loads position 0,0 into the outputs
	always @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			armed     <= 1'b0;
			startSeen <= 1'b0;
		end
		else
		begin
			armed     <= 1'b1;
			startSeen <= startSeen | startCheck;
		end
	end

	// ==================================================
	// Position tracking and checks on the falling edge
	// ==================================================
	always @(negedge iCLK)
	begin
		logic expDen;
		int   key;
		if (!armed)
		begin
			x = 0;
			y = 0;
			first = 1'b1;
			if (lcdHd || lcdVd || lcdDen)
				reportMismatch("sync flags in reset", 24'h0, 24'({lcdHd, lcdVd, lcdDen}));
			if (lcdPixel != '0)
				reportMismatch("pixel in reset", 24'h0, lcdPixel);
		end
		else
		begin
			if (first)
				first = 1'b0;
			else if (x == H_LINE - 1)
			begin
				x = 0;
				y = (y == V_LINE - 1) ? 0 : y + 1;
			end
			else
				x++;
			expDen = (x >= H_BLANK) && (x < H_LINE - H_FRONT) &&
				(y >= V_BACK) && (y < V_LINE - V_FRONT);
			if (lcdHd != (x != 0))
				reportMismatch($sformatf("hd at %0d,%0d", x, y), 24'(x != 0), 24'(lcdHd));
			if (lcdVd != (y != 0))
				reportMismatch($sformatf("vd at %0d,%0d", x, y), 24'(y != 0), 24'(lcdVd));
			if (lcdDen != expDen)
				reportMismatch($sformatf("den at %0d,%0d", x, y), 24'(expDen), 24'(lcdDen));
			if (!lcdDen && lcdPixel != '0)
				reportMismatch($sformatf("blanking at %0d,%0d", x, y), 24'h0, lcdPixel);
			// One full frame from the first frame start after the commits
			if (x == 0 && y == 0)
			begin
				if (checking)
				begin
					checking  = 1'b0;
					checkDone = 1'b1;
					if (probesSeen != probeCount)
					begin
						errorCount++;
						$display("Only %0d of %0d probes were reached", probesSeen, probeCount);
					end
				end
				else if (startSeen && !checkDone)
					checking = 1'b1;
			end
			if (checking)
			begin
				key = y * H_LINE + x;
				if (probeRgb.exists(key))
				begin
					probesSeen++;
					if (lcdPixel != probeRgb[key])
						reportMismatch($sformatf("probe %0d at %0d,%0d", probeNum[key], x, y),
							probeRgb[key], lcdPixel);
				end
			end
		end
	end

endmodule

// File: verif/tbTop.sv
`timescale 1ns/1ps

module tbTop import boardPkg::*; ();

	localparam int H_LINE  = 1056;
	localparam int H_BLANK = 216;
	localparam int H_FRONT = 40;
	localparam int V_LINE  = 525;
	localparam int V_BACK  = 35;
	localparam int V_FRONT = 10;

	logic       iCLK = 1'b0;
	logic       iRST_n;
	rgb_t       bgPixel;
	logic [2:0] currentRow;
	guess_t     liveGuess;
	logic [2:0] blackPegs;
	logic [2:0] whitePegs;
	logic       nextRound;
	logic       lcdHd;
	logic       lcdVd;
	logic       lcdDen;
	rgb_t       lcdPixel;
	logic       startCheck;
	logic       checkDone;
	int         errorCount;
	int         probesSeen;

	// Golden records
	int commitRow [16];
	int commitCol [16][4];
	int commitBlk [16];
	int commitWht [16];
	int nCommit = 0;
	int liveRow;
	int liveCol [4];
	bit fileOk = 1'b1;
	int cycles = 0;
	int cycleLimit = 32'h7fffffff;

	always #4 iCLK = ~iCLK;

	lcdBoardOverlay #(
		.H_LINE(H_LINE), .H_BLANK(H_BLANK), .H_FRONT(H_FRONT),
		.V_LINE(V_LINE), .V_BACK(V_BACK), .V_FRONT(V_FRONT)
	) dut (
		.iCLK(iCLK), .iRST_n(iRST_n), .bgPixel(bgPixel), .currentRow(currentRow),
		.liveGuess(liveGuess), .blackPegs(blackPegs), .whitePegs(whitePegs),
		.nextRound(nextRound), .lcdHd(lcdHd), .lcdVd(lcdVd), .lcdDen(lcdDen),
		.lcdPixel(lcdPixel)
	);

	pixelChecker #(
		.H_LINE(H_LINE), .H_BLANK(H_BLANK), .H_FRONT(H_FRONT),
		.V_LINE(V_LINE), .V_BACK(V_BACK), .V_FRONT(V_FRONT)
	) chk (
		.iCLK(iCLK), .iRST_n(iRST_n), .lcdHd(lcdHd), .lcdVd(lcdVd), .lcdDen(lcdDen),
		.lcdPixel(lcdPixel), .startCheck(startCheck), .checkDone(checkDone),
		.errorCount(errorCount), .probesSeen(probesSeen)
	);

	task readGolden;
		int          fd;
		int          code;
		int          fields;
		int          px;
		int          py;
		string       tag;
		string       line;
		logic [23:0] val;
		fd = $fopen("verif/board_golden.txt", "r");
		if (fd == 0)
			fileOk = 1'b0;
		else
		begin
			while ($fscanf(fd, "%s", tag) == 1)
			begin
				code   = 0;
				fields = 0;
				if (tag == "#")
					void'($fgets(line, fd));
				else if (tag == "B")
				begin
					code = $fscanf(fd, "%h", val);
					fields = 1;
					bgPixel = val;
				end
				else if (tag == "C")
				begin
					code = $fscanf(fd, "%d %d %d %d %d %d %d", commitRow[nCommit],
						commitCol[nCommit][0], commitCol[nCommit][1], commitCol[nCommit][2],
						commitCol[nCommit][3], commitBlk[nCommit], commitWht[nCommit]);
					fields = 7;
					nCommit++;
				end
				else if (tag == "L")
				begin
					code = $fscanf(fd, "%d %d %d %d %d", liveRow,
						liveCol[0], liveCol[1], liveCol[2], liveCol[3]);
					fields = 5;
				end
				else if (tag == "P")
				begin
					code = $fscanf(fd, "%d %d %h", px, py, val);
					fields = 3;
					chk.addProbe(px, py, val);
				end
				else
				begin
					$display("Unknown record in golden file: %s", tag);
					fileOk = 1'b0;
					void'($fgets(line, fd));
				end
				if (code != fields)
				begin
					$display("Incomplete %s record in golden file", tag);
					fileOk = 1'b0;
				end
			end
			$fclose(fd);
		end
	endtask

	// One commit pulse, then a short random idle gap
	task commitRound(input int k);
		int gap;
		@(negedge iCLK);
		currentRow = 3'(commitRow[k]);
		for (int i = 0; i < 4; i++)
			liveGuess[i] = pegColour_e'(3'(commitCol[k][i]));
		blackPegs = 3'(commitBlk[k]);
		whitePegs = 3'(commitWht[k]);
		nextRound = 1'b1;
		@(negedge iCLK);
		nextRound = 1'b0;
		gap = int'($urandom % 4);
		repeat (gap) @(negedge iCLK);
	endtask

	always @(posedge iCLK)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the frame check never finished", cycles);
			$display("Errors: %0d, probes seen: %0d", errorCount, probesSeen);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		iRST_n     = 1'b0;
		nextRound  = 1'b0;
		bgPixel    = '0;
		currentRow = '0;
		liveGuess  = {4{pegEmpty}};
		blackPegs  = '0;
		whitePegs  = '0;
		startCheck = 1'b0;
		void'($urandom(32'h96b866c7));
		readGolden();
		if (!fileOk)
		begin
			$display("Golden file missing or malformed, nothing was run");
			$display("*** FAILED ***");
			$finish;
		end
		else
		begin
			cycleLimit = 3 + nCommit * 6 + 2 * H_LINE * V_LINE + 2000;
			repeat (3) @(negedge iCLK);
			iRST_n = 1'b1;
			for (int k = 0; k < nCommit; k++)
				commitRound(k);
			@(negedge iCLK);
			currentRow = 3'(liveRow); // Live guess held for the checked frame
			for (int i = 0; i < 4; i++)
				liveGuess[i] = pegColour_e'(3'(liveCol[i]));
			startCheck = 1'b1;
			while (!checkDone)
				@(posedge iCLK);
			$display("Errors: %0d, probes seen: %0d", errorCount, probesSeen);
			if (errorCount == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

endmodule
